// ==== reflet_tests.txt ====
# records are T name or L addr word or I ext_int or R or E addr word or D pulses
# addr and word and ext_int in hex and pulses in decimal with programs from 0010

T alu_ops
L 10 19  L 11 38  L 12 12  L 13 39      # r8 gets 9 and r9 gets 2
L 14 28  L 15 05                        # read r8 then push
L 16 1c  L 17 48  L 18 05               # 12 + 9
L 19 1c  L 1a 58  L 1b 05               # 12 - 9
L 1c 1c  L 1d 68  L 1e 05               # 12 and 9
L 1f 1c  L 20 78  L 21 05               # 12 or 9
L 22 1c  L 23 88  L 24 05               # 12 xor 9
L 25 98  L 26 05                        # not 9
L 27 1c  L 28 a9  L 29 05               # 12 shifted left by 2
L 2a 1c  L 2b b9  L 2c 05  L 2d 01      # 12 shifted right by 2 then quit
R
E 80 0009  E 81 0015  E 82 0003
E 83 0008  E 84 000d  E 85 0005
E 86 fff6  E 87 0030  E 88 0003
D 0

T eq_jif_loop
L 10 11  L 11 35  L 12 15  L 13 36      # r5 gets 1 and r6 the limit 5
L 14 21  L 15 37                        # r7 holds the loop start
L 16 24  L 17 45  L 18 34  L 19 c6      # count up and compare
L 1a 22  L 1b 85  L 1c 32  L 1d d7      # flag inverted so jif loops back
L 1e 1c  L 1f 39  L 20 24  L 21 f9  L 22 01
R
E 0c 0005

T mem_stack
L 0e 1234  L 0f 0030                    # data word and subroutine address
L 10 1e  L 11 34  L 12 1d  L 13 35      # r4 gets 0e and r5 gets 0d
L 14 e4  L 15 05  L 16 11  L 17 06  L 18 f5
L 19 1f  L 1a 37  L 1b e7  L 1c 07      # call the subroutine at 0030
L 1d 1b  L 1e 39  L 1f 28  L 20 f9  L 21 01
L 30 17  L 31 38  L 32 03               # subroutine sets r8 to 7 and returns
R
E 0d 1234  E 0b 0007  E 80 001d

T interrupt
L 04 19  L 05 3b  L 06 1e  L 07 fb  L 08 04   # line 0 handler stores 000e at 0009
L 10 18  L 11 32                        # unmask line 0 through sr bit 3
L 12 1a  L 13 3a  L 14 13  L 15 fa  L 16 01
I 1
R
E 09 000e  E 0a 0003

T debug_quit
L 07 beef                               # must survive the store behind quit
L 10 02  L 11 17  L 12 02  L 13 34  L 14 02
L 15 01  L 16 f4  L 17 01
R
E 07 beef
D 3

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= reflet_tb
RTL_TOP    ?= reflet_soc
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  ?= TESTBENCH FAILED
PASS_TEXT  ?= TESTBENCH PASSED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(TB_TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not finish, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
reflet_isa_pkg.sv
reflet_bus_pkg.sv
reflet_alu.sv
reflet_addr.sv
reflet_interrupt.sv
reflet_cpu.sv
reflet_ram.sv
reflet_soc.sv
reflet_tb.sv

// ==== reflet_tb.sv ====
// reads reflet_tests.txt from the working directory; every program has to end in quit
`timescale 1ns/1ps

module reflet_tb;

    localparam int wordsize       = 16;
    localparam int cycles_per_run = 400;
    localparam int name_w         = 8 * 32;

    logic                clk = 1'b0;
    logic                reset;
    logic                enable;
    logic [3:0]          ext_int;
    logic                load_en;
    logic [wordsize-1:0] load_addr;
    logic [wordsize-1:0] load_data;
    logic [wordsize-1:0] peek_addr;
    logic [wordsize-1:0] peek_data;
    logic                quit;
    logic                debug;

    int                  watchdog_cycles = 0;
    int                  errors = 0;
    int                  test_errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  debug_count = 0;
    logic                test_open = 1'b0;
    logic [name_w-1:0]   test_name = '0;

    reflet_soc #(.wordsize(wordsize)) u_reflet_soc (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .ext_int   (ext_int),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .quit      (quit),
        .debug     (debug)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string what, input logic [wordsize-1:0] expected,
        input logic [wordsize-1:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected 0x%h got 0x%h", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("MISMATCH %s expected 0x%0h got 0x%0h", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b0;
        enable = 1'b0;
        ext_int = 4'b0;
        load_en = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
    endtask

    // host port write, core held off by enable low
    task automatic load_word(input logic [wordsize-1:0] addr, input logic [wordsize-1:0] data);
        @(negedge clk);
        load_en = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_program();
        int gap;
        gap = int'($urandom % 32'd8);
        debug_count = 0;
        @(negedge clk);
        repeat (gap) @(negedge clk);
        enable = 1'b1;
        // sampled at the rising edge, before the core updates
        while (!quit)
        begin
            @(posedge clk);
            if (debug)
                debug_count++;
        end
        @(negedge clk);
        enable = 1'b0;
    endtask

    task automatic check_memory(input logic [wordsize-1:0] addr,
        input logic [wordsize-1:0] expected);
        @(negedge clk);
        peek_addr = addr;
        @(posedge clk);
        check_word($sformatf("mem[0x%h]", addr), expected, peek_data);
    endtask

    task automatic finish_test();
        if (test_open)
        begin
            tests_run++;
            if (test_errors == 0)
                $display("test %0s pass", test_name);
            else
            begin
                $display("test %0s fail", test_name);
                tests_failed++;
            end
            errors += test_errors;
            test_open = 1'b0;
        end
    endtask

    // per-run budget plus slack for loads and resets
    task automatic count_cycles(input int fd, output int cycles);
        logic [name_w-1:0] token;
        logic [8*128-1:0]  rest;
        int                runs;
        int                records;
        int                code;
        runs = 0;
        records = 0;
        code = $fscanf(fd, "%s", token);
        while (code == 1)
        begin
            if (token == name_w'("#"))
                code = $fgets(rest, fd);
            else if (token == name_w'("R"))
                runs++;
            else
                records++;
            code = $fscanf(fd, "%s", token);
        end
        cycles = cycles_per_run * runs + 2 * records;
    endtask

    task automatic run_file(input int fd);
        logic [name_w-1:0]   tag;
        logic [7:0]          kind;
        logic [8*128-1:0]    rest;
        logic [wordsize-1:0] addr;
        logic [wordsize-1:0] word;
        logic [3:0]          level;
        int                  expected_count;
        int                  code;
        code = $fscanf(fd, "%s", tag);
        while (code == 1)
        begin
            kind = (|tag[name_w-1:8]) ? 8'h00 : tag[7:0];
            case (kind)
                "#": code = $fgets(rest, fd);
                "T":
                begin
                    finish_test();
                    code = $fscanf(fd, "%s", test_name);
                    test_open = 1'b1;
                    test_errors = 0;
                    apply_reset();
                end
                "L":
                begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    load_word(addr, word);
                end
                "I":
                begin
                    code = $fscanf(fd, "%h", level);
                    @(negedge clk);
                    ext_int = level;
                end
                "R": run_program();
                "E":
                begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    check_memory(addr, word);
                end
                "D":
                begin
                    code = $fscanf(fd, "%d", expected_count);
                    check_count("debug pulses", expected_count, debug_count);
                end
                default:
                begin
                    $display("ERROR: unknown record %0s in the test file", tag);
                    errors++;
                end
            endcase
            code = $fscanf(fd, "%s", tag);
        end
        finish_test();
    endtask

    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: run did not reach quit within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        int fd;
        int seed;
        int budget;
        reset = 1'b0;
        enable = 1'b0;
        ext_int = 4'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        seed = $urandom(32'h3fa9);
        fd = $fopen("reflet_tests.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open reflet_tests.txt for reading");
            $display("TESTBENCH FAILED");
            $finish;
        end
        else
        begin
            count_cycles(fd, budget);
            $fclose(fd);
            watchdog_cycles = budget;
            fd = $fopen("reflet_tests.txt", "r");
            run_file(fd);
            $fclose(fd);
            $display("tests %0d failed %0d check errors %0d", tests_run, tests_failed, errors);
            if (errors == 0 && tests_failed == 0 && tests_run > 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

// ==== reflet_soc.sv ====
// wordsize must equal the bus package word width; RAM covers 2**ram_depth_log2 words
`timescale 1ns/1ps

module reflet_soc
    import reflet_bus_pkg::*;
#(
    parameter int          wordsize         = 16,
    parameter int          ram_depth_log2   = 8,
    parameter int unsigned int_vector_base  = 32'h0004
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [3:0]          ext_int,
    input  logic                load_en,
    input  logic [wordsize-1:0] load_addr,
    input  logic [wordsize-1:0] load_data,
    input  logic [wordsize-1:0] peek_addr,
    output logic [wordsize-1:0] peek_data,
    output logic                quit,
    output logic                debug
);

    bus_req_t            bus;
    logic [wordsize-1:0] rdata;

    reflet_cpu #(
        .wordsize        (wordsize),
        .int_vector_base (int_vector_base)
    ) u_cpu (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .bus     (bus),
        .rdata   (rdata),
        .ext_int (ext_int),
        .quit    (quit),
        .debug   (debug)
    );

    reflet_ram #(
        .wordsize       (wordsize),
        .ram_depth_log2 (ram_depth_log2)
    ) u_ram (
        .clk       (clk),
        .bus       (bus),
        .rdata     (rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    assert property (@(posedge clk) wordsize == word_w);

endmodule

// ==== reflet_ram.sv ====
// contents survive reset; host load wins over a cpu write in the same cycle
`timescale 1ns/1ps

module reflet_ram
    import reflet_bus_pkg::*;
#(
    parameter int wordsize       = 16,
    parameter int ram_depth_log2 = 8
) (
    input  logic                clk,
    input  bus_req_t            bus,
    output logic [wordsize-1:0] rdata,
    input  logic                load_en,
    input  logic [wordsize-1:0] load_addr,
    input  logic [wordsize-1:0] load_data,
    input  logic [wordsize-1:0] peek_addr,
    output logic [wordsize-1:0] peek_data
);

    logic [wordsize-1:0] mem [2**ram_depth_log2];

    // upper address bits ignored
    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_addr[ram_depth_log2-1:0]] <= load_data;
        else if (bus.write_en)
            mem[bus.addr[ram_depth_log2-1:0]] <= bus.data;
        rdata <= mem[bus.addr[ram_depth_log2-1:0]];
    end

    // host side inspection
    assign peek_data = mem[peek_addr[ram_depth_log2-1:0]];

endmodule

// ==== reflet_cpu.sv ====
// multi-cycle core, one instruction at a time; quit freezes the registers until reset
`timescale 1ns/1ps

module reflet_cpu
    import reflet_isa_pkg::*, reflet_bus_pkg::*;
#(
    parameter int          wordsize         = 16,
    parameter int unsigned int_vector_base  = 32'h0004
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    output bus_req_t            bus,
    input  logic [wordsize-1:0] rdata,
    input  logic [3:0]          ext_int,
    output logic                quit,
    output logic                debug
);

    logic [wordsize-1:0] registers [16];
    inst_t               inst;
    reg_wr_t             alu_result;
    reg_wr_t             addr_result;
    reg_wr_t             int_result;
    reg_wr_t             wr_sel;
    logic [wordsize-1:0] sp_next;
    logic                sp_write;
    logic                ram_not_ready;
    logic                interrupt;
    logic                update;
    logic                is_quit;
    logic                is_debug;

    assign update = enable && !ram_not_ready && !quit;
    assign is_quit = inst.op == op_special && inst.arg == spc_quit;
    assign is_debug = inst.op == op_special && inst.arg == spc_debug;
    assign debug = update && !interrupt && is_debug;

    reflet_alu #(.wordsize(wordsize)) u_alu (
        .working_register (registers[wr_id]),
        .other_register   (registers[inst.arg]),
        .status_register  (registers[sr_id]),
        .inst             (inst),
        .result           (alu_result)
    );

    reflet_addr #(.wordsize(wordsize)) u_addr (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .working_register (registers[wr_id]),
        .program_counter  (registers[pc_id]),
        .stack_pointer    (registers[sp_id]),
        .other_register   (registers[inst.arg]),
        .bus              (bus),
        .rdata            (rdata),
        .inst             (inst),
        .result           (addr_result),
        .sp_next          (sp_next),
        .sp_write         (sp_write),
        .ram_not_ready    (ram_not_ready)
    );

    reflet_interrupt #(
        .wordsize        (wordsize),
        .int_vector_base (int_vector_base)
    ) u_interrupt (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .ext_int         (ext_int),
        .inst            (inst),
        .program_counter (registers[pc_id]),
        .int_mask        (registers[sr_id][6:3]),
        .cpu_update      (update),
        .result          (int_result),
        .interrupt       (interrupt)
    );

    // single write port, interrupt first
    always_comb
    begin
        if (int_result.valid)
            wr_sel = int_result;
        else if (is_mem_inst(inst))
            wr_sel = addr_result;
        else
            wr_sel = alu_result;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            registers[wr_id] <= '0;
            registers[sr_id] <= '0;
            registers[pc_id] <= wordsize'(pc_reset);
            registers[sp_id] <= wordsize'(sp_reset);
            for (int i = gp_start; i <= gp_end; i++)
                registers[i] <= '0;
            quit <= 1'b0;
        end
        else if (update)
        begin
            if (wr_sel.valid)
                registers[wr_sel.index] <= wr_sel.value;
            if (sp_write && !interrupt)
                registers[sp_id] <= sp_next;
            // pc stays on quit so nothing behind it gets fetched
            if (!(wr_sel.valid && wr_sel.index == pc_id) && !is_quit)
                registers[pc_id] <= registers[pc_id] + 1'b1;
            if (is_quit && !interrupt)
                quit <= 1'b1;
        end
    end

    // memory left untouched once stopped
    assert property (@(posedge clk) disable iff (!reset) quit |-> !bus.write_en);

endmodule

// ==== reflet_interrupt.sv ====
// one level of service only, lowest line wins; requests are rising-edge latched while enabled
`timescale 1ns/1ps

module reflet_interrupt
    import reflet_isa_pkg::*, reflet_bus_pkg::*;
#(
    parameter int          wordsize         = 16,
    parameter int unsigned int_vector_base  = 32'h0004
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [3:0]          ext_int,
    input  inst_t               inst,
    input  logic [wordsize-1:0] program_counter,
    input  logic [3:0]          int_mask,
    input  logic                cpu_update,
    output reg_wr_t             result,
    output logic                interrupt
);

    logic [3:0]          prev_ext;
    logic [3:0]          pending;
    logic [3:0]          masked;
    logic [3:0]          taken;
    logic [1:0]          line;
    logic                in_service;
    logic                is_reti;
    logic [wordsize-1:0] saved_pc;

    assign masked = pending & int_mask;
    assign interrupt = |masked && !in_service;
    assign is_reti = inst.op == op_special && inst.arg == spc_reti;
    assign taken = (cpu_update && interrupt) ? 4'b0001 << line : 4'b0000;

    // scan downward so the lowest pending line is kept
    always_comb
    begin
        line = 2'd3;
        for (int n = 3; n >= 0; n--)
            if (masked[n])
                line = 2'(n);
    end

    always_comb
    begin
        result = '0;
        result.index = pc_id;
        if (interrupt)
        begin
            result.valid = 1'b1;
            result.value = wordsize'(int_vector_base) + wordsize'(line);
        end
        else if (is_reti)
        begin
            result.valid = 1'b1;
            result.value = saved_pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            prev_ext <= 4'b0;
            pending <= 4'b0;
            in_service <= 1'b0;
        end
        else if (enable)
        begin
            prev_ext <= ext_int;
            pending <= (pending | (ext_int & ~prev_ext)) & ~taken;
            if (cpu_update && interrupt)
                in_service <= 1'b1;
            else if (cpu_update && is_reti)
                in_service <= 1'b0;
        end
    end

    // pc of the instruction that was fetched but not run
    always_ff @(posedge clk)
    begin
        if (enable && cpu_update && interrupt)
            saved_pc <= program_counter;
    end

    assert property (@(posedge clk) disable iff (!reset)
        enable && cpu_update && interrupt |=> in_service && !interrupt);

endmodule

// ==== reflet_addr.sv ====
// word addressed memory, stack grows upward by one word; RAM read data lags address by one cycle
`timescale 1ns/1ps

module reflet_addr
    import reflet_isa_pkg::*, reflet_bus_pkg::*;
#(
    parameter int wordsize = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [wordsize-1:0] working_register,
    input  logic [wordsize-1:0] program_counter,
    input  logic [wordsize-1:0] stack_pointer,
    input  logic [wordsize-1:0] other_register,
    output bus_req_t            bus,
    input  logic [wordsize-1:0] rdata,
    output inst_t               inst,
    output reg_wr_t             result,
    output logic [wordsize-1:0] sp_next,
    output logic                sp_write,
    output logic                ram_not_ready
);

    typedef enum logic [1:0] {
        fetch_addr,
        fetch_data,
        mem_addr,
        mem_data
    } state_t;

    state_t              state;
    inst_t               inst_q;
    special_t            code;
    logic                is_special;
    logic [wordsize-1:0] mem_address;

    // decode straight from the RAM while the fetch data is on rdata
    assign inst = (state == fetch_data) ? inst_t'(rdata[7:0]) : inst_q;
    assign is_special = inst.op == op_special;
    assign code = special_t'(inst.arg);

    // pop and ret read the word below sp
    always_comb
    begin
        if (inst.op == op_load || inst.op == op_store)
            mem_address = other_register;
        else if (code == spc_pop || code == spc_ret)
            mem_address = stack_pointer - 1'b1;
        else
            mem_address = stack_pointer;
    end

    always_comb
    begin
        bus = '0;
        result = '0;
        sp_next = stack_pointer;
        sp_write = 1'b0;
        ram_not_ready = 1'b1;
        case (state)
            fetch_addr, fetch_data:
            begin
                // address held so rdata stays stable if enable drops
                bus.addr = program_counter;
                ram_not_ready = state == fetch_addr || is_mem_inst(inst);
            end
            mem_addr:
            begin
                bus.addr = mem_address;
                bus.data = (is_special && code == spc_call) ?
                    program_counter + 1'b1 : working_register;
                bus.write_en = enable && (inst.op == op_store ||
                    (is_special && (code == spc_push || code == spc_call)));
            end
            default:
            begin
                bus.addr = mem_address;
                ram_not_ready = 1'b0;
                result.valid = inst.op == op_load ||
                    (is_special && code inside {spc_pop, spc_ret, spc_call});
                result.index = (is_special && code != spc_pop) ? pc_id : wr_id;
                result.value = (is_special && code == spc_call) ? working_register : rdata;
                sp_write = is_special;
                sp_next = (code == spc_push || code == spc_call) ?
                    stack_pointer + 1'b1 : stack_pointer - 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= fetch_addr;
            inst_q <= '0;
        end
        else if (enable)
        begin
            case (state)
                fetch_addr: state <= fetch_data;
                fetch_data:
                begin
                    inst_q <= inst;
                    state <= is_mem_inst(inst) ? mem_addr : fetch_addr;
                end
                mem_addr: state <= mem_data;
                default:  state <= fetch_addr;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!reset)
        (state == fetch_addr || state == fetch_data) |-> !bus.write_en);

endmodule

// ==== reflet_alu.sv ====
// purely combinational; cpy into sp is ignored since only the stack path moves sp
`timescale 1ns/1ps

module reflet_alu
    import reflet_isa_pkg::*, reflet_bus_pkg::*;
#(
    parameter int wordsize = 16
) (
    input  logic [wordsize-1:0] working_register,
    input  logic [wordsize-1:0] other_register,
    input  logic [wordsize-1:0] status_register,
    input  inst_t               inst,
    output reg_wr_t             result
);

    logic                valid;
    reg_id_t             index;
    logic [wordsize-1:0] value;

    always_comb
    begin
        valid = 1'b1;
        index = wr_id;
        value = working_register;
        case (inst.op)
            op_set:  value = wordsize'(inst.arg);
            op_read: value = other_register;
            op_cpy:
            begin
                index = inst.arg;
                valid = inst.arg != sp_id;
            end
            op_add:  value = working_register + other_register;
            op_sub:  value = working_register - other_register;
            op_and:  value = working_register & other_register;
            op_or:   value = working_register | other_register;
            op_xor:  value = working_register ^ other_register;
            op_not:  value = ~other_register;
            op_lsl:  value = working_register << other_register;
            op_lsr:  value = working_register >> other_register;
            op_eq:
            begin
                // only the flag bit changes
                index = sr_id;
                value = {status_register[wordsize-1:1], working_register == other_register};
            end
            op_jif:
            begin
                index = pc_id;
                value = other_register;
                valid = status_register[0];
            end
            default: valid = 1'b0;
        endcase
    end

    assign result = '{valid: valid, index: index, value: value};

    always_comb
    begin
        if (result.valid)
            assert (result.index != sp_id) else $error("alu write proposed to sp");
    end

endmodule

// ==== reflet_bus_pkg.sv ====
// word width is fixed at 16 here; the top level wordsize has to agree with word_w
package reflet_bus_pkg;

    localparam int word_w = 16;

    // one request per cycle, the RAM never stalls
    typedef struct packed {
        logic [word_w-1:0] addr;
        logic [word_w-1:0] data;
        logic              write_en;
    } bus_req_t;

    // register write proposal from a unit to the core
    typedef struct packed {
        logic              valid;
        logic [3:0]        index;
        logic [word_w-1:0] value;
    } reg_wr_t;

endpackage

// ==== reflet_isa_pkg.sv ====
// 8-bit instructions in the low byte of a word; unlisted special codes act as nop
package reflet_isa_pkg;

    typedef enum logic [3:0] {
        op_special = 4'd0,
        op_set     = 4'd1,
        op_read    = 4'd2,
        op_cpy     = 4'd3,
        op_add     = 4'd4,
        op_sub     = 4'd5,
        op_and     = 4'd6,
        op_or      = 4'd7,
        op_xor     = 4'd8,
        op_not     = 4'd9,
        op_lsl     = 4'd10,
        op_lsr     = 4'd11,
        op_eq      = 4'd12,
        op_jif     = 4'd13,
        op_load    = 4'd14,
        op_store   = 4'd15
    } op_t;

    // argument meaning when the opcode is special
    typedef enum logic [3:0] {
        spc_nop   = 4'd0,
        spc_quit  = 4'd1,
        spc_debug = 4'd2,
        spc_ret   = 4'd3,
        spc_reti  = 4'd4,
        spc_push  = 4'd5,
        spc_pop   = 4'd6,
        spc_call  = 4'd7
    } special_t;

    typedef logic [3:0] reg_id_t;

    localparam reg_id_t wr_id    = 4'd0;
    localparam reg_id_t pc_id    = 4'd1;
    localparam reg_id_t sr_id    = 4'd2;
    localparam reg_id_t sp_id    = 4'd3;
    localparam reg_id_t gp_start = 4'd4;
    localparam reg_id_t gp_end   = 4'd15;

    localparam logic [15:0] pc_reset = 16'h0010;
    localparam logic [15:0] sp_reset = 16'h0080;

    typedef struct packed {
        op_t        op;
        logic [3:0] arg;
    } inst_t;

    // instructions that need the extra memory cycles
    function automatic logic is_mem_inst(inst_t i);
        return i.op == op_load || i.op == op_store ||
            (i.op == op_special && i.arg inside {spc_ret, spc_push, spc_pop, spc_call});
    endfunction

endpackage
